//--- project.f
mem_pkg.sv
mem_arbiter.sv
bank_decoder.sv
sram_bank.sv
bank_resp_mux.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- Makefile
TOP = tb_mem_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

    import mem_pkg::*;

    logic              clk, rst;
    logic              imem_arvalid, imem_rready, imem_arready, imem_rvalid, imem_rlast;
    logic              dmem_arvalid, dmem_rready, dmem_arready, dmem_rvalid, dmem_rlast;
    logic              dmem_awvalid, dmem_wvalid, dmem_wlast, dmem_bready;
    logic              dmem_awready, dmem_wready, dmem_bvalid;
    logic [ADDR_W-1:0] imem_araddr, dmem_araddr, dmem_awaddr;
    id_t               imem_arid, imem_rid, dmem_arid, dmem_rid, dmem_awid, dmem_bid;
    logic [LEN_W-1:0]  imem_arlen, dmem_arlen, dmem_awlen;
    logic [2:0]        imem_arsize, dmem_arsize, dmem_awsize;
    logic [1:0]        imem_arburst, dmem_arburst, dmem_awburst;
    word_t             imem_rdata, dmem_rdata, dmem_wdata;
    resp_t             imem_rresp, dmem_rresp, dmem_bresp;
    logic [STRB_W-1:0] dmem_wstrb;

    // Reference copy of all banks
    word_t       model [NUM_BANKS*BANK_WORDS];
    logic [15:0] lfsr = 16'd21481;
    int          errors = 0;
    int          beats_issued = 0;
    int          cycle = 0;
    int          ifu_first_rvalid = 0;
    int          lsu_last_beat = 0;

    mem_subsystem DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        return take_bits(32) & 32'hFFFF_FFFC;
    endfunction

    // Bank from bits 11:10, word from bits 9:2, wrapping inside the bank
    function automatic int word_index(input logic [ADDR_W-1:0] addr, input int beat);
        logic [WORD_IDX_W-1:0] word;
        word = addr[9:2] + WORD_IDX_W'(beat);
        return int'(addr[11:10]) * BANK_WORDS + int'(word);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected resp %0d, actual resp %0d", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected id %h, actual id %h", name, exp, act);
        end
    endtask

    task automatic write_burst(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [LEN_W-1:0] len, input id_t id,
                               input logic [1:0] burst, input logic [2:0] size,
                               input bit rand_strb, input bit stall);
        bit                legal;
        bit                got;
        word_t             data;
        logic [STRB_W-1:0] strb;
        legal = (burst == INCR) && (size == 3'd2);
        beats_issued += int'(len) + 1;
        @(negedge clk);
        dmem_awvalid = 1'b1;
        dmem_awaddr  = addr;
        dmem_awid    = id;
        dmem_awlen   = len;
        dmem_awsize  = size;
        dmem_awburst = burst;
        #1;
        while (!dmem_awready) begin
            @(negedge clk);
            #1;
        end
        for (int beat = 0; beat <= int'(len); beat++) begin
            data = take_bits(32);
            strb = rand_strb ? STRB_W'(take_bits(4)) : '1;
            @(negedge clk);
            dmem_awvalid = 1'b0;
            dmem_wvalid  = 1'b1;
            dmem_wdata   = data;
            dmem_wstrb   = strb;
            dmem_wlast   = (beat == int'(len));
            #1;
            while (!dmem_wready) begin
                @(negedge clk);
                #1;
            end
            if (legal) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (strb[b]) begin
                        model[word_index(addr, beat)][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
        end
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            dmem_wvalid = 1'b0;
            dmem_wlast  = 1'b0;
            dmem_bready = stall ? 1'(take_bits(1)) : 1'b1;
            #1;
            got = dmem_bvalid && dmem_bready;
        end
        check_resp(name, legal ? OKAY : SLVERR, dmem_bresp);
        check_id(name, id, dmem_bid);
        @(negedge clk);
        dmem_bready = 1'b0;
    endtask

    task automatic read_burst(input bit lsu, input string name, input logic [ADDR_W-1:0] addr,
                              input logic [LEN_W-1:0] len, input id_t id,
                              input logic [1:0] burst, input logic [2:0] size,
                              input bit stall);
        bit    legal;
        bit    done;
        bit    rdy;
        int    beat;
        string tag;
        legal = (burst == INCR) && (size == 3'd2);
        beats_issued += int'(len) + 1;
        @(negedge clk);
        if (lsu) begin
            dmem_arvalid = 1'b1;
            dmem_araddr  = addr;
            dmem_arid    = id;
            dmem_arlen   = len;
            dmem_arsize  = size;
            dmem_arburst = burst;
        end else begin
            imem_arvalid = 1'b1;
            imem_araddr  = addr;
            imem_arid    = id;
            imem_arlen   = len;
            imem_arsize  = size;
            imem_arburst = burst;
        end
        #1;
        while (!(lsu ? dmem_arready : imem_arready)) begin
            @(negedge clk);
            #1;
        end
        beat = 0;
        done = 1'b0;
        while (!done) begin
            rdy = stall ? 1'(take_bits(1)) : 1'b1;
            @(negedge clk);
            if (lsu) begin
                dmem_arvalid = 1'b0;
                dmem_rready  = rdy;
            end else begin
                imem_arvalid = 1'b0;
                imem_rready  = rdy;
            end
            #1;
            if (!lsu && imem_rvalid && ifu_first_rvalid == 0) begin
                ifu_first_rvalid = cycle;
            end
            if ((lsu ? dmem_rvalid : imem_rvalid) && rdy) begin
                tag = $sformatf("%s beat %0d", name, beat);
                check_word(tag, legal ? model[word_index(addr, beat)] : '0,
                           lsu ? dmem_rdata : imem_rdata);
                check_resp(tag, legal ? OKAY : SLVERR, lsu ? dmem_rresp : imem_rresp);
                check_id(tag, id, lsu ? dmem_rid : imem_rid);
                if (lsu) begin
                    lsu_last_beat = cycle;
                end
                if (beat == int'(len)) begin
                    if (!(lsu ? dmem_rlast : imem_rlast)) begin
                        errors++;
                        $display("%s: rlast missing on the final beat", tag);
                    end
                    done = 1'b1;
                end else if (lsu ? dmem_rlast : imem_rlast) begin
                    errors++;
                    $display("%s: rlast came before the final beat", tag);
                    done = 1'b1;
                end
                beat++;
            end
        end
        @(negedge clk);
        if (lsu) begin
            dmem_rready = 1'b0;
        end else begin
            imem_rready = 1'b0;
        end
    endtask

    // Limit grows with every burst issued
    initial begin
        while (cycle < 1000 + 20 * beats_issued) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycle);
        $display("Errors: %0d, beats issued: %0d", errors, beats_issued);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        id_t               id;
        {imem_arvalid, imem_rready, dmem_arvalid, dmem_rready} = '0;
        {dmem_awvalid, dmem_wvalid, dmem_wlast, dmem_bready} = '0;
        {imem_araddr, dmem_araddr, dmem_awaddr} = '0;
        {imem_arid, dmem_arid, dmem_awid} = '0;
        {imem_arlen, dmem_arlen, dmem_awlen} = '0;
        {imem_arsize, dmem_arsize, dmem_awsize} = '0;
        {imem_arburst, dmem_arburst, dmem_awburst} = '0;
        dmem_wdata = '0;
        dmem_wstrb = '0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fill every bank so later reads are all defined
        for (int b = 0; b < NUM_BANKS; b++) begin
            write_burst($sformatf("fill bank %0d", b), ADDR_W'(b) << BANK_LSB, 8'd255,
                        ID_W'(b), INCR, 3'd2, 1'b0, 1'b0);
        end

        for (int i = 0; i < 12; i++) begin
            addr = rand_addr();
            len  = LEN_W'(take_bits(3));
            id   = ID_W'(take_bits(4));
            write_burst($sformatf("lsu write %0d", i), addr, len, id, INCR, 3'd2, 1'b1, 1'b1);
            read_burst(1'b1, $sformatf("lsu read %0d", i), addr, len, ID_W'(take_bits(4)),
                       INCR, 3'd2, 1'b1);
        end

        for (int i = 0; i < 8; i++) begin
            read_burst(1'b0, $sformatf("ifu read %0d", i), rand_addr(), LEN_W'(take_bits(3)),
                       ID_W'(take_bits(4)), INCR, 3'd2, 1'b1);
        end

        // Both masters raise AR on one edge
        ifu_first_rvalid = 0;
        lsu_last_beat    = 0;
        addr = rand_addr();
        fork
            read_burst(1'b1, "race lsu", addr, 8'd5, 4'h3, INCR, 3'd2, 1'b1);
            read_burst(1'b0, "race ifu", addr ^ 32'h0000_0400, 8'd3, 4'h9, INCR, 3'd2, 1'b1);
        join
        if (ifu_first_rvalid <= lsu_last_beat) begin
            errors++;
            $display("IFU read data arrived before the LSU burst had finished");
        end

        // Word 253 of bank 2 with upper address bits set
        addr = 32'h4000_0BF4;
        write_burst("wrap write", addr, 8'd5, 4'hA, INCR, 3'd2, 1'b1, 1'b1);
        read_burst(1'b1, "wrap lsu read", addr, 8'd5, 4'hB, INCR, 3'd2, 1'b1);
        read_burst(1'b0, "wrap ifu read", addr & 32'h0000_0FFF, 8'd5, 4'hC, INCR, 3'd2, 1'b0);
        // Start of bank 2 read without wrapping
        read_burst(1'b1, "wrap bank start read", 32'h0000_0800, 8'd2, 4'hD, INCR, 3'd2, 1'b0);

        addr = rand_addr();
        write_burst("fixed write", addr, 8'd3, 4'h5, FIXED, 3'd2, 1'b1, 1'b0);
        write_burst("narrow write", addr, 8'd3, 4'h6, INCR, 3'd1, 1'b1, 1'b0);
        read_burst(1'b1, "wrap type read", addr, 8'd3, 4'h7, WRAP, 3'd2, 1'b0);
        read_burst(1'b0, "narrow read", addr, 8'd3, 4'h8, INCR, 3'd0, 1'b0);
        read_burst(1'b1, "read after slverr", addr, 8'd3, 4'h2, INCR, 3'd2, 1'b0);

        $display("Errors: %0d, beats issued: %0d", errors, beats_issued);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       imem_arvalid, imem_rready,
    output logic                       imem_arready, imem_rvalid, imem_rlast,
    input  logic [mem_pkg::ADDR_W-1:0] imem_araddr,
    input  mem_pkg::id_t               imem_arid,
    input  logic [mem_pkg::LEN_W-1:0]  imem_arlen,
    input  logic [2:0]                 imem_arsize,
    input  logic [1:0]                 imem_arburst,
    output mem_pkg::word_t             imem_rdata,
    output mem_pkg::resp_t             imem_rresp,
    output mem_pkg::id_t               imem_rid,

    input  logic                       dmem_arvalid, dmem_rready,
    output logic                       dmem_arready, dmem_rvalid, dmem_rlast,
    input  logic [mem_pkg::ADDR_W-1:0] dmem_araddr,
    input  mem_pkg::id_t               dmem_arid,
    input  logic [mem_pkg::LEN_W-1:0]  dmem_arlen,
    input  logic [2:0]                 dmem_arsize,
    input  logic [1:0]                 dmem_arburst,
    output mem_pkg::word_t             dmem_rdata,
    output mem_pkg::resp_t             dmem_rresp,
    output mem_pkg::id_t               dmem_rid,

    input  logic                       dmem_awvalid, dmem_wvalid, dmem_wlast, dmem_bready,
    output logic                       dmem_awready, dmem_wready, dmem_bvalid,
    input  logic [mem_pkg::ADDR_W-1:0] dmem_awaddr,
    input  mem_pkg::id_t               dmem_awid,
    input  logic [mem_pkg::LEN_W-1:0]  dmem_awlen,
    input  logic [2:0]                 dmem_awsize,
    input  logic [1:0]                 dmem_awburst,
    input  mem_pkg::word_t             dmem_wdata,
    input  logic [mem_pkg::STRB_W-1:0] dmem_wstrb,
    output mem_pkg::resp_t             dmem_bresp,
    output mem_pkg::id_t               dmem_bid
);

    import mem_pkg::*;

    logic                  mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    logic                  mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_wlast;
    logic                  mem_bvalid, mem_bready;
    logic [ADDR_W-1:0]     mem_araddr, mem_awaddr;
    id_t                   mem_arid, mem_rid, mem_awid, mem_bid;
    logic [LEN_W-1:0]      mem_arlen, mem_awlen;
    logic [2:0]            mem_arsize, mem_awsize;
    logic [1:0]            mem_arburst, mem_awburst;
    word_t                 mem_rdata, mem_wdata;
    logic [STRB_W-1:0]     mem_wstrb;
    resp_t                 mem_rresp, mem_bresp;

    logic [NUM_BANKS-1:0]  bank_arvalid, bank_arready, bank_awvalid, bank_awready;
    logic [NUM_BANKS-1:0]  bank_wvalid, bank_wready, bank_rvalid, bank_rready, bank_rlast;
    logic [NUM_BANKS-1:0]  bank_bvalid, bank_bready;
    logic [WORD_IDX_W-1:0] bank_araddr, bank_awaddr;
    id_t                   bank_arid, bank_awid;
    logic [LEN_W-1:0]      bank_arlen, bank_awlen;
    logic [2:0]            bank_arsize, bank_awsize;
    logic [1:0]            bank_arburst, bank_awburst;
    word_t                 bank_wdata;
    logic [STRB_W-1:0]     bank_wstrb;
    logic                  bank_wlast;
    word_t [NUM_BANKS-1:0] bank_rdata;
    resp_t [NUM_BANKS-1:0] bank_rresp, bank_bresp;
    id_t   [NUM_BANKS-1:0] bank_rid, bank_bid;

    mem_arbiter u_arbiter (.*);

    bank_decoder u_decoder (.*);

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        sram_bank u_bank (
            .clk     (clk),
            .rst     (rst),
            .arvalid (bank_arvalid[g]),
            .arready (bank_arready[g]),
            .araddr  (bank_araddr),
            .arid    (bank_arid),
            .arlen   (bank_arlen),
            .arsize  (bank_arsize),
            .arburst (bank_arburst),
            .rvalid  (bank_rvalid[g]),
            .rlast   (bank_rlast[g]),
            .rready  (bank_rready[g]),
            .rdata   (bank_rdata[g]),
            .rresp   (bank_rresp[g]),
            .rid     (bank_rid[g]),
            .awvalid (bank_awvalid[g]),
            .awready (bank_awready[g]),
            .awaddr  (bank_awaddr),
            .awid    (bank_awid),
            .awlen   (bank_awlen),
            .awsize  (bank_awsize),
            .awburst (bank_awburst),
            .wvalid  (bank_wvalid[g]),
            .wlast   (bank_wlast),
            .wready  (bank_wready[g]),
            .wdata   (bank_wdata),
            .wstrb   (bank_wstrb),
            .bvalid  (bank_bvalid[g]),
            .bready  (bank_bready[g]),
            .bresp   (bank_bresp[g]),
            .bid     (bank_bid[g])
        );
    end

    bank_resp_mux u_resp_mux (.*);

endmodule

//--- bank_resp_mux.sv
`timescale 1ns/1ns

module bank_resp_mux (
    input  logic [mem_pkg::NUM_BANKS-1:0]           bank_rvalid, bank_rlast, bank_bvalid,
    input  mem_pkg::word_t [mem_pkg::NUM_BANKS-1:0] bank_rdata,
    input  mem_pkg::resp_t [mem_pkg::NUM_BANKS-1:0] bank_rresp, bank_bresp,
    input  mem_pkg::id_t   [mem_pkg::NUM_BANKS-1:0] bank_rid, bank_bid,
    output logic                                    mem_rvalid, mem_rlast, mem_bvalid,
    output mem_pkg::word_t                          mem_rdata,
    output mem_pkg::resp_t                          mem_rresp, mem_bresp,
    output mem_pkg::id_t                            mem_rid, mem_bid,
    input  logic                                    mem_rready, mem_bready,
    output logic [mem_pkg::NUM_BANKS-1:0]           bank_rready, bank_bready
);

    import mem_pkg::*;

    logic [BANK_IDX_W-1:0] r_idx, b_idx;

    // Lowest valid bank wins
    always_comb begin
        r_idx = '0;
        b_idx = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (bank_rvalid[i]) begin
                r_idx = BANK_IDX_W'(i);
            end
            if (bank_bvalid[i]) begin
                b_idx = BANK_IDX_W'(i);
            end
        end
    end

    assign mem_rvalid  = |bank_rvalid;
    assign mem_rdata   = bank_rdata[r_idx];
    assign mem_rresp   = bank_rresp[r_idx];
    assign mem_rid     = bank_rid[r_idx];
    assign mem_rlast   = bank_rlast[r_idx];
    assign bank_rready = NUM_BANKS'(mem_rvalid & mem_rready) << r_idx;

    assign mem_bvalid  = |bank_bvalid;
    assign mem_bresp   = bank_bresp[b_idx];
    assign mem_bid     = bank_bid[b_idx];
    assign bank_bready = NUM_BANKS'(mem_bvalid & mem_bready) << b_idx;

endmodule

//--- sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           arvalid,
    output logic                           arready,
    input  logic [mem_pkg::WORD_IDX_W-1:0] araddr,
    input  mem_pkg::id_t                   arid,
    input  logic [mem_pkg::LEN_W-1:0]      arlen,
    input  logic [2:0]                     arsize,
    input  logic [1:0]                     arburst,
    output logic                           rvalid, rlast,
    input  logic                           rready,
    output mem_pkg::word_t                 rdata,
    output mem_pkg::resp_t                 rresp,
    output mem_pkg::id_t                   rid,

    input  logic                           awvalid,
    output logic                           awready,
    input  logic [mem_pkg::WORD_IDX_W-1:0] awaddr,
    input  mem_pkg::id_t                   awid,
    input  logic [mem_pkg::LEN_W-1:0]      awlen,
    input  logic [2:0]                     awsize,
    input  logic [1:0]                     awburst,
    input  logic                           wvalid, wlast,
    output logic                           wready,
    input  mem_pkg::word_t                 wdata,
    input  logic [mem_pkg::STRB_W-1:0]     wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output mem_pkg::resp_t                 bresp,
    output mem_pkg::id_t                   bid
);

    import mem_pkg::*;

    word_t                 mem [BANK_WORDS];
    bank_state_t           state;
    logic [WORD_IDX_W-1:0] rd_addr, wr_addr;
    logic [LEN_W-1:0]      rd_cnt, wr_cnt;
    logic                  rd_ok, wr_ok;
    logic                  ar_fire, aw_fire, r_fire, w_fire;

    assign arready = (state == BK_IDLE);
    // A read waiting in the same cycle goes first
    assign awready = (state == BK_IDLE) && !arvalid;
    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign r_fire  = rvalid && rready;
    assign w_fire  = wvalid && wready;

    assign rvalid = (state == BK_READ);
    assign rdata  = rd_ok ? mem[rd_addr] : '0;
    assign rresp  = rd_ok ? OKAY : SLVERR;
    assign rlast  = (rd_cnt == '0);
    assign wready = (state == BK_WRITE);
    assign bvalid = (state == BK_RESP);
    assign bresp  = wr_ok ? OKAY : SLVERR;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BK_IDLE;
        end else begin
            case (state)
                BK_IDLE: begin
                    if (ar_fire) begin
                        state <= BK_READ;
                    end else if (aw_fire) begin
                        state <= BK_WRITE;
                    end
                end
                BK_READ:  if (r_fire && rlast) state <= BK_IDLE;
                BK_WRITE: if (w_fire && wlast) state <= BK_RESP;
                BK_RESP:  if (bready) state <= BK_IDLE;
                default:  state <= BK_IDLE;
            endcase
        end
    end

    // Word index wraps inside the bank
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
            rd_cnt  <= arlen;
            rid     <= arid;
            rd_ok   <= (arburst == INCR) && (arsize == BEAT_SIZE);
        end else if (r_fire) begin
            rd_addr <= rd_addr + 1'b1;
            rd_cnt  <= rd_cnt - 1'b1;
        end
        if (aw_fire) begin
            wr_addr <= awaddr;
            wr_cnt  <= awlen;
            bid     <= awid;
            wr_ok   <= (awburst == INCR) && (awsize == BEAT_SIZE);
        end else if (w_fire) begin
            wr_addr <= wr_addr + 1'b1;
            wr_cnt  <= wr_cnt - 1'b1;
            // wlast off the counted beat fails the rest of the burst
            if (wlast != (wr_cnt == '0)) begin
                wr_ok <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[wr_addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- bank_decoder.sv
`timescale 1ns/1ns

module bank_decoder (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           mem_arvalid,
    output logic                           mem_arready,
    input  logic [mem_pkg::ADDR_W-1:0]     mem_araddr,
    input  mem_pkg::id_t                   mem_arid,
    input  logic [mem_pkg::LEN_W-1:0]      mem_arlen,
    input  logic [2:0]                     mem_arsize,
    input  logic [1:0]                     mem_arburst,

    input  logic                           mem_awvalid,
    output logic                           mem_awready,
    input  logic [mem_pkg::ADDR_W-1:0]     mem_awaddr,
    input  mem_pkg::id_t                   mem_awid,
    input  logic [mem_pkg::LEN_W-1:0]      mem_awlen,
    input  logic [2:0]                     mem_awsize,
    input  logic [1:0]                     mem_awburst,

    input  logic                           mem_wvalid, mem_wlast,
    output logic                           mem_wready,
    input  mem_pkg::word_t                 mem_wdata,
    input  logic [mem_pkg::STRB_W-1:0]     mem_wstrb,

    output logic [mem_pkg::NUM_BANKS-1:0]  bank_arvalid, bank_awvalid, bank_wvalid,
    input  logic [mem_pkg::NUM_BANKS-1:0]  bank_arready, bank_awready, bank_wready,
    output logic [mem_pkg::WORD_IDX_W-1:0] bank_araddr, bank_awaddr,
    output mem_pkg::id_t                   bank_arid, bank_awid,
    output logic [mem_pkg::LEN_W-1:0]      bank_arlen, bank_awlen,
    output logic [2:0]                     bank_arsize, bank_awsize,
    output logic [1:0]                     bank_arburst, bank_awburst,
    output mem_pkg::word_t                 bank_wdata,
    output logic [mem_pkg::STRB_W-1:0]     bank_wstrb,
    output logic                           bank_wlast
);

    import mem_pkg::*;

    logic [BANK_IDX_W-1:0] ar_bank, aw_bank, w_bank;
    logic                  w_active;

    assign ar_bank = mem_araddr[BANK_LSB +: BANK_IDX_W];
    assign aw_bank = mem_awaddr[BANK_LSB +: BANK_IDX_W];

    assign bank_arvalid = NUM_BANKS'(mem_arvalid) << ar_bank;
    assign mem_arready  = bank_arready[ar_bank];
    assign bank_awvalid = NUM_BANKS'(mem_awvalid) << aw_bank;
    assign mem_awready  = bank_awready[aw_bank];

    // Banks see only the word index
    assign bank_araddr  = mem_araddr[WORD_LSB +: WORD_IDX_W];
    assign bank_arid    = mem_arid;
    assign bank_arlen   = mem_arlen;
    assign bank_arsize  = mem_arsize;
    assign bank_arburst = mem_arburst;
    assign bank_awaddr  = mem_awaddr[WORD_LSB +: WORD_IDX_W];
    assign bank_awid    = mem_awid;
    assign bank_awlen   = mem_awlen;
    assign bank_awsize  = mem_awsize;
    assign bank_awburst = mem_awburst;
    assign bank_wdata   = mem_wdata;
    assign bank_wstrb   = mem_wstrb;
    assign bank_wlast   = mem_wlast;

    // W beats follow the bank latched at the AW transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            w_active <= 1'b0;
            w_bank   <= '0;
        end else if (mem_awvalid && mem_awready) begin
            w_active <= 1'b1;
            w_bank   <= aw_bank;
        end else if (mem_wvalid && mem_wready && mem_wlast) begin
            w_active <= 1'b0;
        end
    end

    assign bank_wvalid = NUM_BANKS'(w_active & mem_wvalid) << w_bank;
    assign mem_wready  = w_active & bank_wready[w_bank];

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       imem_arvalid, imem_rready,
    output logic                       imem_arready, imem_rvalid, imem_rlast,
    input  logic [mem_pkg::ADDR_W-1:0] imem_araddr,
    input  mem_pkg::id_t               imem_arid,
    input  logic [mem_pkg::LEN_W-1:0]  imem_arlen,
    input  logic [2:0]                 imem_arsize,
    input  logic [1:0]                 imem_arburst,
    output mem_pkg::word_t             imem_rdata,
    output mem_pkg::resp_t             imem_rresp,
    output mem_pkg::id_t               imem_rid,

    input  logic                       dmem_arvalid, dmem_rready,
    output logic                       dmem_arready, dmem_rvalid, dmem_rlast,
    input  logic [mem_pkg::ADDR_W-1:0] dmem_araddr,
    input  mem_pkg::id_t               dmem_arid,
    input  logic [mem_pkg::LEN_W-1:0]  dmem_arlen,
    input  logic [2:0]                 dmem_arsize,
    input  logic [1:0]                 dmem_arburst,
    output mem_pkg::word_t             dmem_rdata,
    output mem_pkg::resp_t             dmem_rresp,
    output mem_pkg::id_t               dmem_rid,

    input  logic                       dmem_awvalid, dmem_wvalid, dmem_wlast, dmem_bready,
    output logic                       dmem_awready, dmem_wready, dmem_bvalid,
    input  logic [mem_pkg::ADDR_W-1:0] dmem_awaddr,
    input  mem_pkg::id_t               dmem_awid,
    input  logic [mem_pkg::LEN_W-1:0]  dmem_awlen,
    input  logic [2:0]                 dmem_awsize,
    input  logic [1:0]                 dmem_awburst,
    input  mem_pkg::word_t             dmem_wdata,
    input  logic [mem_pkg::STRB_W-1:0] dmem_wstrb,
    output mem_pkg::resp_t             dmem_bresp,
    output mem_pkg::id_t               dmem_bid,

    output logic                       mem_arvalid, mem_rready,
    input  logic                       mem_arready, mem_rvalid, mem_rlast,
    output logic [mem_pkg::ADDR_W-1:0] mem_araddr,
    output mem_pkg::id_t               mem_arid,
    output logic [mem_pkg::LEN_W-1:0]  mem_arlen,
    output logic [2:0]                 mem_arsize,
    output logic [1:0]                 mem_arburst,
    input  mem_pkg::word_t             mem_rdata,
    input  mem_pkg::resp_t             mem_rresp,
    input  mem_pkg::id_t               mem_rid,

    output logic                       mem_awvalid, mem_wvalid, mem_wlast, mem_bready,
    input  logic                       mem_awready, mem_wready, mem_bvalid,
    output logic [mem_pkg::ADDR_W-1:0] mem_awaddr,
    output mem_pkg::id_t               mem_awid,
    output logic [mem_pkg::LEN_W-1:0]  mem_awlen,
    output logic [2:0]                 mem_awsize,
    output logic [1:0]                 mem_awburst,
    output mem_pkg::word_t             mem_wdata,
    output logic [mem_pkg::STRB_W-1:0] mem_wstrb,
    input  mem_pkg::resp_t             mem_bresp,
    input  mem_pkg::id_t               mem_bid
);

    import mem_pkg::*;

    rd_state_t rd_state, rd_state_n;
    wr_state_t wr_state, wr_state_n;
    logic      ifu_ar, lsu_ar, ifu_r, lsu_r;
    logic      aw_sel, w_sel, b_sel;

    assign ifu_ar = (rd_state == RD_IFU_AR);
    assign lsu_ar = (rd_state == RD_LSU_AR);
    assign ifu_r  = (rd_state == RD_IFU_R);
    assign lsu_r  = (rd_state == RD_LSU_R);
    assign aw_sel = (wr_state == WR_AW);
    assign w_sel  = (wr_state == WR_W);
    assign b_sel  = (wr_state == WR_B);

    // Granted master's AR request
    assign mem_arvalid = (ifu_ar & imem_arvalid) | (lsu_ar & dmem_arvalid);
    assign mem_araddr  = ifu_ar ? imem_araddr  : lsu_ar ? dmem_araddr  : '0;
    assign mem_arid    = ifu_ar ? imem_arid    : lsu_ar ? dmem_arid    : '0;
    assign mem_arlen   = ifu_ar ? imem_arlen   : lsu_ar ? dmem_arlen   : '0;
    assign mem_arsize  = ifu_ar ? imem_arsize  : lsu_ar ? dmem_arsize  : '0;
    assign mem_arburst = ifu_ar ? imem_arburst : lsu_ar ? dmem_arburst : '0;
    assign imem_arready = ifu_ar & mem_arready;
    assign dmem_arready = lsu_ar & mem_arready;

    assign imem_rvalid = ifu_r & mem_rvalid;
    assign imem_rdata  = ifu_r ? mem_rdata : '0;
    assign imem_rresp  = ifu_r ? mem_rresp : OKAY;
    assign imem_rid    = ifu_r ? mem_rid   : '0;
    assign imem_rlast  = ifu_r & mem_rlast;
    assign dmem_rvalid = lsu_r & mem_rvalid;
    assign dmem_rdata  = lsu_r ? mem_rdata : '0;
    assign dmem_rresp  = lsu_r ? mem_rresp : OKAY;
    assign dmem_rid    = lsu_r ? mem_rid   : '0;
    assign dmem_rlast  = lsu_r & mem_rlast;
    assign mem_rready  = (ifu_r & imem_rready) | (lsu_r & dmem_rready);

    // LSU write path
    assign mem_awvalid  = aw_sel & dmem_awvalid;
    assign mem_awaddr   = aw_sel ? dmem_awaddr  : '0;
    assign mem_awid     = aw_sel ? dmem_awid    : '0;
    assign mem_awlen    = aw_sel ? dmem_awlen   : '0;
    assign mem_awsize   = aw_sel ? dmem_awsize  : '0;
    assign mem_awburst  = aw_sel ? dmem_awburst : '0;
    assign dmem_awready = aw_sel & mem_awready;

    assign mem_wvalid  = w_sel & dmem_wvalid;
    assign mem_wdata   = w_sel ? dmem_wdata : '0;
    assign mem_wstrb   = w_sel ? dmem_wstrb : '0;
    assign mem_wlast   = w_sel & dmem_wlast;
    assign dmem_wready = w_sel & mem_wready;

    assign dmem_bvalid = b_sel & mem_bvalid;
    assign dmem_bresp  = b_sel ? mem_bresp : OKAY;
    assign dmem_bid    = b_sel ? mem_bid   : '0;
    assign mem_bready  = b_sel & dmem_bready;

    // LSU wins when both masters wait in idle
    always_comb begin
        rd_state_n = rd_state;
        case (rd_state)
            RD_IDLE: begin
                if (dmem_arvalid) begin
                    rd_state_n = RD_LSU_AR;
                end else if (imem_arvalid) begin
                    rd_state_n = RD_IFU_AR;
                end
            end
            RD_IFU_AR, RD_LSU_AR: begin
                if (mem_arvalid && mem_arready) begin
                    rd_state_n = ifu_ar ? RD_IFU_R : RD_LSU_R;
                end
            end
            RD_IFU_R, RD_LSU_R: begin
                if (mem_rvalid && mem_rready && mem_rlast) begin
                    rd_state_n = RD_IDLE;
                end
            end
            default: rd_state_n = RD_IDLE;
        endcase
    end

    always_comb begin
        wr_state_n = wr_state;
        case (wr_state)
            WR_IDLE: if (dmem_awvalid) wr_state_n = WR_AW;
            WR_AW:   if (mem_awvalid && mem_awready) wr_state_n = WR_W;
            WR_W:    if (mem_wvalid && mem_wready && mem_wlast) wr_state_n = WR_B;
            WR_B:    if (mem_bvalid && mem_bready) wr_state_n = WR_IDLE;
            default: wr_state_n = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
        end else begin
            rd_state <= rd_state_n;
            wr_state <= wr_state_n;
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    // Word index sits above the byte offset, bank index above the word index
    localparam int NUM_BANKS  = 4;
    localparam int BANK_WORDS = 256;
    localparam int BANK_IDX_W = 2;
    localparam int WORD_IDX_W = 8;
    localparam int WORD_LSB   = 2;
    localparam int BANK_LSB   = WORD_LSB + WORD_IDX_W;

    // Only full 4-byte beats
    localparam logic [2:0] BEAT_SIZE = 3'd2;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ID_W-1:0]   id_t;

    typedef enum logic [1:0] {OKAY = 2'd0, SLVERR = 2'd2} resp_t;
    typedef enum logic [1:0] {FIXED, INCR, WRAP} burst_t;

    typedef enum logic [2:0] {RD_IDLE, RD_IFU_AR, RD_IFU_R, RD_LSU_AR, RD_LSU_R} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_AW, WR_W, WR_B} wr_state_t;
    typedef enum logic [1:0] {BK_IDLE, BK_READ, BK_WRITE, BK_RESP} bank_state_t;

endpackage
